// File: Makefile
# Verilator build and run for the multislope ADC controller testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_top
BUILD     ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/tb_spi_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: bench/tb_spi_tasks.svh
/* SPI mode 1 master tasks, value checks and the LFSR used by the ADC testbench;
   included inside the testbench module so the tasks drive its signals directly */
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// galois lfsr, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

// shifts 32 bits, cs left low so the caller picks when the write commits
task automatic spi_shift(input logic [7:0] addr, input logic [23:0] value,
                         output logic [23:0] rdata);
  logic [31:0] frame;
  frame = {addr, value};
  rdata = '0;
  @(posedge clk);
  spi_cs_n <= 1'b0;
  repeat (spi_half) @(posedge clk);
  for (int i = 31; i >= 0; i--)
  begin
    // mode 1, change on rise
    spi_clk  <= 1'b1;
    spi_mosi <= frame[i];
    repeat (spi_half) @(posedge clk);
    // data half of the frame, sample just before the fall
    if (i < 24)
    begin
      @(negedge clk);
      rdata = {rdata[22:0], spi_miso};
      @(posedge clk);
    end
    spi_clk <= 1'b0;
    repeat (spi_half) @(posedge clk);
  end
endtask

task automatic spi_end();
  @(posedge clk);
  spi_cs_n <= 1'b1;
  repeat (spi_half + 4) @(posedge clk);
endtask

task automatic reg_write(input logic [6:0] addr, input logic [23:0] value);
  logic [23:0] unused;
  spi_shift({1'b0, addr}, value, unused);
  spi_end();
endtask

// flag bit set, so a read never writes
task automatic reg_read(input logic [6:0] addr, output logic [23:0] value);
  spi_shift({1'b1, addr}, 24'h000000, value);
  spi_end();
endtask

task automatic check_value(input string name, input logic [23:0] got,
                           input logic [23:0] exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

`endif

// File: bench/tb_adc_top.sv
/* testbench for the multislope ADC controller with an integrator model on lomux,
   SPI register tests and measurement checks against a monitor of the outputs */
`timescale 1ns/100ps

module tb_adc_top;

  localparam int clk_period  = 40;
  localparam int spi_half    = 6;
  localparam int frame_clks  = 420;
  localparam int frame_total = 45;
  // default init, short integration, long integration
  localparam int meas_clks   = 10000 + 600 + 20000;
  localparam longint timeout_ns = longint'(clk_period) * (4 * meas_clks + frame_total * frame_clks);

  // reference codes on lomux[1:0]
  localparam logic [1:0] code_none = 2'd0;
  localparam logic [1:0] code_pos  = 2'd1;
  localparam logic [1:0] code_neg  = 2'd2;
  localparam logic [1:0] code_slow = 2'd3;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic cmp_out = 1'b0;
  logic spi_clk = 1'b0;
  logic spi_cs_n = 1'b1;
  logic spi_mosi = 1'b0;
  logic spi_miso;
  logic [2:0] lomux;
  logic [3:0] himux;
  logic cmp_latch;
  logic eoc_n;

  logic [31:0] lfsr_state = 32'h540cf152;
  int errors = 0;
  int checks = 0;
  int mon_errors = 0;
  int acc = 0;
  int sig_level = 0;

  // monitor state
  int cnt_up, cnt_down, rd_cnt, none_sig_cycles;
  int eoc_count = 0;
  int snap_up, snap_down, snap_rd;
  logic [1:0] prev_ref, snap_ref;
  logic prev_eoc, in_runup;

  `include "tb_spi_tasks.svh"

  adc_top uut (
    .clk(clk), .reset(reset), .cmp_out(cmp_out),
    .spi_clk(spi_clk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
    .lomux(lomux), .himux(himux), .cmp_latch(cmp_latch), .eoc_n(eoc_n)
  );

  initial
  begin
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // integrator model reads the outputs mid cycle
  always @(negedge clk)
  begin
    if (reset)
      acc = 0;
    else
    begin
      if (lomux[2])
        acc = acc + sig_level;
      case (lomux[1:0])
        code_pos:  acc = acc - 8;
        code_neg:  acc = acc + 8;
        code_slow: acc = acc - 1;
        default:   ;
      endcase
    end
  end

  // comparator high below zero
  always @(posedge clk)
    cmp_out <= (acc < 0);

  //////////////////////////////////////////////////
  // output monitor
  always @(negedge clk)
  begin
    if (reset)
    begin
      cnt_up = 0;
      cnt_down = 0;
      rd_cnt = 0;
      none_sig_cycles = 0;
      in_runup = 1'b0;
      prev_ref = code_none;
      prev_eoc = 1'b1;
    end
    else
    begin
      if (!eoc_n)
      begin
        if (!prev_eoc)
        begin
          mon_errors++;
          $display("eoc_n stayed low for a second cycle at %0t", $time);
        end
        if (lomux[2])
        begin
          mon_errors++;
          $display("signal switch still on at end of conversion, %0t", $time);
        end
        snap_up = cnt_up;
        snap_down = cnt_down;
        snap_rd = rd_cnt;
        snap_ref = prev_ref;
        cnt_up = 0;
        cnt_down = 0;
        in_runup = 1'b0;
        eoc_count++;
      end
      else
      begin
        if (lomux[1:0] != prev_ref && lomux[1:0] == code_neg)
          cnt_up++;
        if (lomux[1:0] != prev_ref && lomux[1:0] == code_pos)
          cnt_down++;
        // slow rundown start is visible as a new code
        if (lomux[1:0] == code_slow && prev_ref != code_slow)
        begin
          rd_cnt = 0;
          if (lomux[2])
          begin
            mon_errors++;
            $display("signal switch on when rundown started, %0t", $time);
          end
        end
        else
          rd_cnt++;
        if (in_runup && lomux[1:0] == code_none)
        begin
          mon_errors++;
          $display("reference switched off during runup at %0t", $time);
        end
        if (lomux[1:0] != code_none)
          in_runup = 1'b1;
        // one cycle allowed between init end and the first fixed phase
        if (lomux[2] && lomux[1:0] == code_none)
          none_sig_cycles++;
        else
          none_sig_cycles = 0;
        if (none_sig_cycles > 1)
        begin
          mon_errors++;
          $display("signal switch on outside runup at %0t", $time);
        end
      end
      prev_ref = lomux[1:0];
      prev_eoc = eoc_n;
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  initial
  begin
    logic [6:0]  cfg_addrs [7];
    logic [23:0] cfg_masks [7];
    logic [23:0] cfg_dflts [7];
    logic [23:0] wval [7];
    logic [23:0] got, dummy, cu, cd, ru, tu, td, fu, fd;
    logic [3:0]  hm;
    int n0;
    cfg_addrs = '{7'd18, 7'd20, 7'd21, 7'd22, 7'd23, 7'd24, 7'd25};
    cfg_masks = '{24'hffffff, 24'hffffff, 24'hffffff, 24'hffffff, 24'h0000ff,
                  24'h000001, 24'h00000f};
    cfg_dflts = '{24'd10000, 24'd700, 24'd5500, 24'h3d0900, 24'h000000,
                  24'h000001, 24'h00000b};
    sig_level = int'(rand_bits(3)) - 4;

    apply_reset();
    checks++;
    if (eoc_n !== 1'b1 || lomux !== 3'b000 || cmp_latch !== 1'b0)
    begin
      errors++;
      $display("Error at %0t: reset outputs eoc_n %b lomux %b cmp_latch %b, expected 1 000 0",
               $time, eoc_n, lomux, cmp_latch);
    end
    for (int i = 0; i < 7; i++)
    begin
      reg_read(cfg_addrs[i], got);
      check_value($sformatf("default reg %0d", cfg_addrs[i]), got, cfg_dflts[i]);
    end
    reg_read(7'd15, got);
    check_value("test word", got, 24'hffffff);

    // random writes and readback
    for (int i = 0; i < 7; i++)
    begin
      wval[i] = 24'(rand_bits(24));
      // a value equal to the default would hide a lost write
      if ((wval[i] & cfg_masks[i]) == cfg_dflts[i])
        wval[i] = ~wval[i];
      reg_write(cfg_addrs[i], wval[i]);
    end
    for (int i = 0; i < 7; i++)
    begin
      reg_read(cfg_addrs[i], got);
      check_value($sformatf("written reg %0d", cfg_addrs[i]), got, wval[i] & cfg_masks[i]);
    end
    spi_shift({1'b1, 7'd20}, ~wval[1], dummy);
    spi_end();
    reg_read(7'd20, got);
    check_value("fix_n after read-only frame", got, wval[1]);

    //////////////////////////////////////////////////
    // short measurement with init_n committed just after the first eoc
    apply_reset();
    hm = 4'(rand_bits(4));
    // must differ from the reset default to show the load
    if (hm == 4'b1011)
      hm = ~hm;
    reg_write(7'd20, 24'd5);
    reg_write(7'd21, 24'd20);
    reg_write(7'd22, 24'd600);
    reg_write(7'd23, 24'd0);
    reg_write(7'd24, 24'd1);
    reg_write(7'd25, {20'h00000, hm});
    n0 = eoc_count;
    spi_shift({1'b0, 7'd18}, 24'd20, dummy);
    wait (eoc_count == n0 + 1);
    spi_end();
    wait (eoc_count == n0 + 2);
    check_value("rundown code, slow", {22'h0, snap_ref}, {22'h0, code_slow});
    check_value("himux", {20'h0, himux}, {20'h0, hm});
    // longer next run so the results stay put while read
    reg_write(7'd22, 24'd20000);
    reg_read(7'd9, cu);
    reg_read(7'd10, cd);
    reg_read(7'd11, ru);
    reg_read(7'd12, tu);
    reg_read(7'd14, td);
    reg_read(7'd26, fu);
    reg_read(7'd27, fd);
    check_value("fix_up vs fix_down", fu, fd);
    check_value("count_up + count_down", cu + cd, 24'(2 * int'(fu)));
    check_value("trans_up", tu, 24'(snap_up));
    check_value("trans_down", td, 24'(snap_down));
    check_value("rundown_clks", ru, 24'(snap_rd));
    checks++;
    if (fu == 24'd0)
    begin
      errors++;
      $display("measurement ran no runup cycle");
    end

    // fast rundown
    reg_write(7'd24, 24'd0);
    wait (eoc_count == n0 + 3);
    check_value("rundown code, fast", {22'h0, snap_ref}, {22'h0, code_pos});
    check_value("himux", {20'h0, himux}, {20'h0, hm});

    $display("errors: %0d, monitor errors: %0d, checks: %0d", errors, mon_errors, checks);
    if (errors + mon_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    #(timeout_ns);
    $display("watchdog expired, a measurement or SPI frame never completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: rtl/adc_pkg.sv
/* shared types, register map and reset defaults for the multislope ADC controller;
   every other file refers to these by adc_pkg:: scoped names */
package adc_pkg;

  // widths that carry a meaning
  typedef logic [23:0] count_t;
  typedef logic [31:0] int_count_t;
  typedef logic [6:0]  reg_addr_t;
  // active low: signal, ref hi, ref lo, slope ground
  typedef logic [3:0]  himux_t;

  // reference switch codes, as driven onto lomux[1:0]
  typedef enum logic [1:0] {
    ref_none     = 2'd0,
    ref_pos      = 2'd1,  // integrator down
    ref_neg      = 2'd2,  // integrator up
    ref_slow_pos = 2'd3   // integrator down, slow slope
  } ref_sel_e;

  typedef enum logic [3:0] {
    init_start, init,
    fix_pos_start, fix_pos,
    var_start, var_run,
    fix_neg_start, fix_neg,
    var2_start, var2,
    rundown_start, rundown,
    done
  } mod_state_e;

  // 109 bits
  typedef struct packed {
    count_t     init_n;
    count_t     fix_n;
    count_t     var_n;
    int_count_t int_n;
    logic       use_slow_rundown;
    himux_t     himux_sel;
  } mod_config_t;

  // 168 bits
  typedef struct packed {
    count_t count_up;
    count_t count_down;
    count_t trans_up;
    count_t trans_down;
    count_t fix_up;
    count_t fix_down;
    count_t rundown_clks;
  } meas_result_t;

  //////////////////////////////////////////////////
  // register map, read only results
  localparam reg_addr_t addr_count_up     = 7'd9;
  localparam reg_addr_t addr_count_down   = 7'd10;
  localparam reg_addr_t addr_rundown_clks = 7'd11;
  localparam reg_addr_t addr_trans_up     = 7'd12;
  localparam reg_addr_t addr_trans_down   = 7'd14;
  localparam reg_addr_t addr_test_word    = 7'd15;
  localparam reg_addr_t addr_fix_up       = 7'd26;
  localparam reg_addr_t addr_fix_down     = 7'd27;

  // read/write configuration
  localparam reg_addr_t addr_init_n       = 7'd18;
  localparam reg_addr_t addr_fix_n        = 7'd20;
  localparam reg_addr_t addr_var_n        = 7'd21;
  localparam reg_addr_t addr_int_lo       = 7'd22;
  localparam reg_addr_t addr_int_hi       = 7'd23;
  localparam reg_addr_t addr_slow_rundown = 7'd24;
  localparam reg_addr_t addr_himux_sel    = 7'd25;

  //////////////////////////////////////////////////
  // defaults loaded by reset
  localparam mod_config_t cfg_defaults = '{
    init_n:           24'd10000,
    fix_n:            24'd700,
    var_n:            24'd5500,
    int_n:            32'd4000000,  // 200 ms at 20 MHz
    use_slow_rundown: 1'b1,
    himux_sel:        4'b1011       // ref lo, ie. input shorted
  };

  // 8 bit address then 24 bit value
  localparam int     spi_frame_bits  = 32;
  localparam count_t test_word_value = 24'hffffff;

endpackage

// File: rtl/adc_top.sv
/* multislope ADC controller top, joins the sequencer, phase timer,
   slope counters and SPI register bank */
`timescale 1ns/100ps

module adc_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            cmp_out,
  input  logic            spi_clk,
  input  logic            spi_cs_n,
  input  logic            spi_mosi,
  output logic            spi_miso,
  // signal switch, then reference pair
  output logic [2:0]      lomux,
  output adc_pkg::himux_t himux,
  output logic            cmp_latch,
  output logic            eoc_n
);

  adc_pkg::mod_config_t  cfg;
  adc_pkg::meas_result_t result;
  adc_pkg::count_t       phase_count;
  logic                  int_done;
  logic                  phase_clear;
  logic                  int_clear;
  logic                  counters_clear;
  logic                  dir_up;
  logic                  dir_down;
  logic                  trans_up_inc;
  logic                  trans_down_inc;
  logic                  fix_up_inc;
  logic                  fix_down_inc;
  logic                  capture;

  // ref_sel also appears in lomux[1:0]
  modulation_ctrl u_ctrl (
    .clk, .reset, .cmp_out, .cfg, .phase_count, .int_done,
    .lomux, .himux, .eoc_n, .cmp_latch,
    .phase_clear, .int_clear, .counters_clear, .dir_up, .dir_down,
    .trans_up_inc, .trans_down_inc, .fix_up_inc, .fix_down_inc, .capture,
    .ref_sel ()
  );

  phase_timer u_timer (
    .clk, .reset, .phase_clear, .int_clear, .cfg, .phase_count, .int_done
  );

  slope_counters u_counters (
    .clk, .reset, .counters_clear, .dir_up, .dir_down,
    .trans_up_inc, .trans_down_inc, .fix_up_inc, .fix_down_inc,
    .capture, .phase_count, .result
  );

  spi_reg_bank u_regs (
    .clk, .reset, .spi_clk, .spi_cs_n, .spi_mosi, .spi_miso, .result, .cfg
  );

endmodule

// File: rtl/modulation_ctrl.sv
/* multislope sequencer with init settle, four phase runup cycles and a rundown
   to a comparator cross, then one cycle of end-of-conversion interrupt */
`timescale 1ns/100ps

module modulation_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmp_out,
  input  adc_pkg::mod_config_t cfg,
  input  adc_pkg::count_t      phase_count,
  input  logic                 int_done,
  output logic [2:0]           lomux,
  output adc_pkg::himux_t      himux,
  output logic                 eoc_n,
  output logic                 cmp_latch,
  output logic                 phase_clear,
  output logic                 int_clear,
  output logic                 counters_clear,
  output logic                 dir_up,
  output logic                 dir_down,
  output logic                 trans_up_inc,
  output logic                 trans_down_inc,
  output logic                 fix_up_inc,
  output logic                 fix_down_inc,
  output logic                 capture,
  output adc_pkg::ref_sel_e    ref_sel
);

  adc_pkg::mod_state_e state;
  adc_pkg::ref_sel_e   ref_next;
  logic [2:0]          cmp_sync;
  logic                cmp_low;
  logic                cmp_cross;
  logic                ref_load;
  logic                sig_on;

  // comparator high means integrator below zero
  always_ff @(posedge clk)
  begin
    if (reset)
      cmp_sync <= '0;
    else
      cmp_sync <= {cmp_sync[1:0], cmp_out};
  end

  assign cmp_low   = cmp_sync[1];
  assign cmp_cross = cmp_sync[2] ^ cmp_sync[1];

  assign lomux     = {sig_on, ref_sel};
  // latch enable held low so the latch stays transparent
  assign cmp_latch = 1'b0;

  //////////////////////////////////////////////////
  // per-state strobes and next reference
  always_comb
  begin
    phase_clear    = 1'b0;
    int_clear      = 1'b0;
    counters_clear = 1'b0;
    dir_up         = 1'b0;
    dir_down       = 1'b0;
    fix_up_inc     = 1'b0;
    fix_down_inc   = 1'b0;
    capture        = 1'b0;
    ref_load       = 1'b0;
    ref_next       = ref_sel;
    case (state)
      adc_pkg::init_start:
      begin
        phase_clear    = 1'b1;
        int_clear      = 1'b1;
        counters_clear = 1'b1;
      end
      adc_pkg::fix_pos_start:
      begin
        phase_clear  = 1'b1;
        fix_down_inc = 1'b1;
        ref_load     = 1'b1;
        ref_next     = adc_pkg::ref_pos;
      end
      adc_pkg::var_start, adc_pkg::var2_start:
      begin
        phase_clear = 1'b1;
        ref_load    = 1'b1;
        // below zero so push up
        if (cmp_low)
        begin
          ref_next = adc_pkg::ref_neg;
          dir_up   = 1'b1;
        end
        else
        begin
          ref_next = adc_pkg::ref_pos;
          dir_down = 1'b1;
        end
      end
      adc_pkg::fix_neg_start:
      begin
        phase_clear = 1'b1;
        fix_up_inc  = 1'b1;
        ref_load    = 1'b1;
        ref_next    = adc_pkg::ref_neg;
      end
      adc_pkg::rundown_start:
      begin
        phase_clear = 1'b1;
        ref_load    = 1'b1;
        ref_next    = cfg.use_slow_rundown ? adc_pkg::ref_slow_pos : adc_pkg::ref_pos;
      end
      adc_pkg::rundown:
        capture = cmp_cross;
      default:
        ;
    endcase
  end

  // count only real switch changes
  assign trans_up_inc   = ref_load && (ref_next == adc_pkg::ref_neg)
                          && (ref_sel != adc_pkg::ref_neg);
  assign trans_down_inc = ref_load && (ref_next == adc_pkg::ref_pos)
                          && (ref_sel != adc_pkg::ref_pos);

  //////////////////////////////////////////////////
  // state machine
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= adc_pkg::init_start;
      ref_sel <= adc_pkg::ref_none;
      sig_on  <= 1'b0;
      himux   <= adc_pkg::cfg_defaults.himux_sel;
      eoc_n   <= 1'b1;
    end
    else
    begin
      // signal stays off once integration time is up
      if (int_done)
        sig_on <= 1'b0;
      if (ref_load)
        ref_sel <= ref_next;
      case (state)
        adc_pkg::init_start:
        begin
          state   <= adc_pkg::init;
          himux   <= cfg.himux_sel;
          sig_on  <= 1'b0;
          ref_sel <= adc_pkg::ref_none;
          eoc_n   <= 1'b1;
        end
        adc_pkg::init:
          if (phase_count == cfg.init_n)
          begin
            state  <= adc_pkg::fix_pos_start;
            sig_on <= !int_done;
          end
        adc_pkg::fix_pos_start:
          state <= adc_pkg::fix_pos;
        adc_pkg::fix_pos:
          if (phase_count == cfg.fix_n)
            state <= adc_pkg::var_start;
        adc_pkg::var_start:
          state <= adc_pkg::var_run;
        adc_pkg::var_run:
          if (phase_count == cfg.var_n)
            state <= adc_pkg::fix_neg_start;
        adc_pkg::fix_neg_start:
          state <= adc_pkg::fix_neg;
        adc_pkg::fix_neg:
          if (phase_count == cfg.fix_n)
            state <= adc_pkg::var2_start;
        adc_pkg::var2_start:
          state <= adc_pkg::var2;
        adc_pkg::var2:
          // another runup cycle unless time is up and the integrator is above zero
          if (phase_count == cfg.var_n)
            state <= (int_done && !cmp_low) ? adc_pkg::rundown_start
                                            : adc_pkg::fix_pos_start;
        adc_pkg::rundown_start:
          state <= adc_pkg::rundown;
        adc_pkg::rundown:
          if (capture)
          begin
            state   <= adc_pkg::done;
            ref_sel <= adc_pkg::ref_none;
            eoc_n   <= 1'b0;
          end
        adc_pkg::done:
        begin
          eoc_n <= 1'b1;
          state <= adc_pkg::init_start;
        end
        default:
          state <= adc_pkg::init_start;
      endcase
    end
  end

  // interrupt is a single clock pulse
  a_eoc_one_cycle: assert property (
    @(posedge clk) disable iff (reset) !eoc_n |=> eoc_n);

endmodule

// File: rtl/phase_timer.sv
/* clock counters for the current phase and for total integration time,
   with the sticky integration-done flag used by the modulation FSM */
`timescale 1ns/100ps

module phase_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 phase_clear,
  input  logic                 int_clear,
  input  adc_pkg::mod_config_t cfg,
  output adc_pkg::count_t      phase_count,
  output logic                 int_done
);

  adc_pkg::int_count_t int_count;

  // clocks since last *_start state
  always_ff @(posedge clk)
  begin
    if (reset || phase_clear)
      phase_count <= '0;
    else
      phase_count <= phase_count + 1'b1;
  end

  // integration time, holds once the limit is hit
  always_ff @(posedge clk)
  begin
    if (reset || int_clear)
    begin
      int_count <= '0;
      int_done  <= 1'b0;
    end
    else if (int_count >= cfg.int_n)
      int_done <= 1'b1;
    else
      int_count <= int_count + 1'b1;
  end

endmodule

// File: rtl/slope_counters.sv
/* running slope and transition counters for one measurement;
   the whole set is copied into result when the rundown crosses zero */
`timescale 1ns/100ps

module slope_counters (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  counters_clear,
  input  logic                  dir_up,
  input  logic                  dir_down,
  input  logic                  trans_up_inc,
  input  logic                  trans_down_inc,
  input  logic                  fix_up_inc,
  input  logic                  fix_down_inc,
  input  logic                  capture,
  input  adc_pkg::count_t       phase_count,
  output adc_pkg::meas_result_t result
);

  adc_pkg::count_t count_up;
  adc_pkg::count_t count_down;
  adc_pkg::count_t trans_up;
  adc_pkg::count_t trans_down;
  adc_pkg::count_t fix_up;
  adc_pkg::count_t fix_down;

  //////////////////////////////////////////////////
  // running counts
  always_ff @(posedge clk)
  begin
    if (reset || counters_clear)
    begin
      count_up   <= '0;
      count_down <= '0;
      trans_up   <= '0;
      trans_down <= '0;
      fix_up     <= '0;
      fix_down   <= '0;
    end
    else
    begin
      // variable phases
      if (dir_up)
        count_up <= count_up + 1'b1;
      if (dir_down)
        count_down <= count_down + 1'b1;
      // reference switch changes
      if (trans_up_inc)
        trans_up <= trans_up + 1'b1;
      if (trans_down_inc)
        trans_down <= trans_down + 1'b1;
      if (fix_up_inc)
        fix_up <= fix_up + 1'b1;
      if (fix_down_inc)
        fix_down <= fix_down + 1'b1;
    end
  end

  // last finished run, phase_count is the rundown length here
  always_ff @(posedge clk)
  begin
    if (capture)
      result <= '{count_up, count_down, trans_up, trans_down,
                  fix_up, fix_down, phase_count};
  end

  // one variable phase decision per start state
  a_dir_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(dir_up && dir_down));

endmodule

// File: rtl/spi_reg_bank.sv
/* SPI mode 1 slave, oversampled on clk, holding the configuration registers
   and giving readback of config and the latched measurement results */
`timescale 1ns/100ps

module spi_reg_bank (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 spi_clk,
  input  logic                 spi_cs_n,
  input  logic                 spi_mosi,
  output logic                 spi_miso,
  input  adc_pkg::meas_result_t result,
  output adc_pkg::mod_config_t  cfg
);

  logic [2:0] sclk_sync;
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_fall;
  logic       cs_rise;
  logic       cs_active;
  logic [6:0] bit_cnt;
  logic [adc_pkg::spi_frame_bits-1:0] in_sr;
  logic [adc_pkg::spi_frame_bits-1:0] out_sr;
  adc_pkg::reg_addr_t rd_addr;
  adc_pkg::reg_addr_t wr_addr;
  adc_pkg::count_t    rd_value;
  adc_pkg::count_t    wr_value;
  logic               wr_en;

  //////////////////////////////////////////////////
  // pin synchronisers, third stage for edges
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], spi_clk};
      cs_sync   <= {cs_sync[1:0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  // mode 1, sample on falling edge
  assign sclk_fall = sclk_sync[2] & ~sclk_sync[1];
  assign cs_rise   = ~cs_sync[2] & cs_sync[1];
  assign cs_active = ~cs_sync[1];

  // address complete with the bit arriving now, top flag bit dropped
  assign rd_addr = {in_sr[5:0], mosi_sync[1]};

  //////////////////////////////////////////////////
  // frame shifting
  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_fall)
      in_sr <= {in_sr[adc_pkg::spi_frame_bits-2:0], mosi_sync[1]};
  end

  always_ff @(posedge clk)
  begin
    if (reset || !cs_active)
    begin
      bit_cnt <= '0;
      out_sr  <= '0;
    end
    else if (sclk_fall)
    begin
      bit_cnt <= bit_cnt + 1'b1;
      // eighth bit in, master samples value msb on the next fall
      if (bit_cnt == 7'd7)
        out_sr <= {rd_value, 8'h00};
      else
        out_sr <= out_sr << 1;
    end
  end

  assign spi_miso = out_sr[adc_pkg::spi_frame_bits-1];

  // read mux, unknown addresses give zero
  always_comb
  begin
    case (rd_addr)
      adc_pkg::addr_count_up:     rd_value = result.count_up;
      adc_pkg::addr_count_down:   rd_value = result.count_down;
      adc_pkg::addr_rundown_clks: rd_value = result.rundown_clks;
      adc_pkg::addr_trans_up:     rd_value = result.trans_up;
      adc_pkg::addr_trans_down:   rd_value = result.trans_down;
      adc_pkg::addr_fix_up:       rd_value = result.fix_up;
      adc_pkg::addr_fix_down:     rd_value = result.fix_down;
      adc_pkg::addr_test_word:    rd_value = adc_pkg::test_word_value;
      adc_pkg::addr_init_n:       rd_value = cfg.init_n;
      adc_pkg::addr_fix_n:        rd_value = cfg.fix_n;
      adc_pkg::addr_var_n:        rd_value = cfg.var_n;
      adc_pkg::addr_int_lo:       rd_value = cfg.int_n[23:0];
      adc_pkg::addr_int_hi:       rd_value = {16'h0000, cfg.int_n[31:24]};
      adc_pkg::addr_slow_rundown: rd_value = {23'h000000, cfg.use_slow_rundown};
      adc_pkg::addr_himux_sel:    rd_value = {20'h00000, cfg.himux_sel};
      default:                    rd_value = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // write at end of frame, full length and flag clear only
  assign wr_en    = cs_rise && (bit_cnt == 7'd32) && !in_sr[31];
  assign wr_addr  = in_sr[30:24];
  assign wr_value = in_sr[23:0];

  always_ff @(posedge clk)
  begin
    if (reset)
      cfg <= adc_pkg::cfg_defaults;
    else if (wr_en)
    begin
      case (wr_addr)
        adc_pkg::addr_init_n:       cfg.init_n <= wr_value;
        adc_pkg::addr_fix_n:        cfg.fix_n <= wr_value;
        adc_pkg::addr_var_n:        cfg.var_n <= wr_value;
        adc_pkg::addr_int_lo:       cfg.int_n[23:0] <= wr_value;
        adc_pkg::addr_int_hi:       cfg.int_n[31:24] <= wr_value[7:0];
        adc_pkg::addr_slow_rundown: cfg.use_slow_rundown <= wr_value[0];
        adc_pkg::addr_himux_sel:    cfg.himux_sel <= wr_value[3:0];
        default:                    ;
      endcase
    end
  end

  // the pin must already be high when the delayed edge commits a write
  a_no_write_in_frame: assert property (
    @(posedge clk) disable iff (reset) wr_en |-> spi_cs_n);

endmodule

// File: sim.f
+incdir+bench
rtl/adc_pkg.sv
rtl/spi_reg_bank.sv
rtl/phase_timer.sv
rtl/slope_counters.sv
rtl/modulation_ctrl.sv
rtl/adc_top.sv
bench/tb_adc_top.sv
